// ==== sources.f ====
hw/conv_pkg.sv
hw/ctrl_pkg.sv
hw/img_port_if.sv
hw/delay_line.sv
hw/conv_ctrl.sv
hw/conv_core.sv
hw/img_mem.sv
hw/net_mem.sv
hw/conv_unit.sv
bench/tb_clock.sv
bench/tb_conv_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_conv_unit
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_conv_unit.sv ====
`timescale 1ns/100ps

module tb_conv_unit
  import conv_pkg::*;
  ;

  localparam int IMG_WORDS = 2**IMGSIZE;
  localparam int MAX_CH    = 8;
  localparam int NCASES    = 6;

  typedef struct packed {
    logic [LWIDTH-1:0]  img_size;
    logic [LWIDTH-1:0]  total_in;
    logic [LWIDTH-1:0]  total_out;
    logic [IMGSIZE-1:0] in_offset;
    logic [IMGSIZE-1:0] out_offset;
    logic [NETSIZE-1:0] net_offset;
    logic [DWIDTH-1:0]  mask;
    logic               stray_req;
  } case_t;

  // size, in, out, in_offset, out_offset, net_offset, mask, stray req
  localparam case_t CASES [NCASES] = '{
    '{8'd3, 8'd1, 8'd2, 10'd0,   10'd100, 6'd0,  16'h000F, 1'b0},
    '{8'd4, 8'd3, 8'd2, 10'd16,  10'd200, 6'd5,  16'h00FF, 1'b0},
    '{8'd3, 8'd2, 8'd4, 10'd40,  10'd300, 6'd3,  16'h003F, 1'b0},
    '{8'd5, 8'd2, 8'd2, 10'd500, 10'd600, 6'd0,  16'hFFFF, 1'b1},
    '{8'd8, 8'd4, 8'd4, 10'd0,   10'd512, 6'd10, 16'h0FFF, 1'b0},
    '{8'd1, 8'd2, 8'd2, 10'd900, 10'd950, 6'd40, 16'hFFFF, 1'b1}
  };

  logic                     clk;
  logic                     xrst;
  logic                     req;
  logic                     ack;
  logic        [LWIDTH-1:0]  total_in;
  logic        [LWIDTH-1:0]  total_out;
  logic        [LWIDTH-1:0]  img_size;
  logic        [IMGSIZE-1:0] in_offset;
  logic        [IMGSIZE-1:0] out_offset;
  logic        [NETSIZE-1:0] net_offset;
  logic                     net_we;
  logic        [CORELOG-1:0] net_sel;
  logic        [NETSIZE-1:0] net_addr;
  logic signed [DWIDTH-1:0]  net_wdata;
  logic                     img_we;
  logic        [IMGSIZE-1:0] img_addr;
  logic signed [DWIDTH-1:0]  img_wdata;
  logic signed [DWIDTH-1:0]  img_rdata;

  logic        [15:0]        lfsr_state;
  logic signed [DWIDTH-1:0]  img_model [IMG_WORDS];
  logic signed [DWIDTH-1:0]  weight    [MAX_CH][MAX_CH];
  logic signed [DWIDTH-1:0]  bias      [MAX_CH];

  tb_clock #(.PERIOD_NS(100)) i_tb_clock (.clk);

  conv_unit i_conv_unit
    ( .clk, .xrst, .req, .ack
    , .total_in, .total_out, .img_size
    , .in_offset, .out_offset, .net_offset
    , .net_we, .net_sel, .net_addr, .net_wdata
    , .img_we, .img_addr, .img_wdata, .img_rdata
    );

// ====================
// helpers
// ====================

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    // x^16 + x^14 + x^13 + x^11 + 1
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_word(input logic [DWIDTH-1:0] mask, output logic [DWIDTH-1:0] w);
    w = '0;
    for (int b = 0; b < DWIDTH; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[DWIDTH-2:0], lfsr_state[0]};
    end
    w = w & mask;
  endtask

  // odd multiplier keeps every address distinct
  function automatic logic [DWIDTH-1:0] background(input int addr, input int idx);
    return DWIDTH'(addr * 40503 + idx * 7919) ^ 16'h5AC3;
  endfunction

  task automatic check_equal(input string what, input logic [DWIDTH-1:0] actual,
                             input logic [DWIDTH-1:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic write_img(input int addr, input logic signed [DWIDTH-1:0] data);
    img_we    = 1'b1;
    img_addr  = IMGSIZE'(addr);
    img_wdata = data;
    @(negedge clk);
    img_we    = 1'b0;
  endtask

  task automatic read_img(input int addr, output logic signed [DWIDTH-1:0] data);
    img_addr = IMGSIZE'(addr);
    @(negedge clk);
    data = img_rdata;
  endtask

  task automatic write_net(input int bank, input int addr, input logic signed [DWIDTH-1:0] data);
    net_we    = 1'b1;
    net_sel   = CORELOG'(bank);
    net_addr  = NETSIZE'(addr);
    net_wdata = data;
    @(negedge clk);
    net_we    = 1'b0;
  endtask

  // twice the phase cycles plus host load and readback
  function automatic int run_budget();
    int cycles;
    int npix;
    int ti;
    cycles = 16;
    for (int i = 0; i < NCASES; i++) begin
      npix = int'(CASES[i].img_size) * int'(CASES[i].img_size);
      ti   = int'(CASES[i].total_in);
      cycles += (int'(CASES[i].total_out) / CORES)
              * (ti + 1 + ti * npix + CORES * npix + RD_DELAY);
      cycles += 2 * IMG_WORDS + int'(CASES[i].total_out) * (ti + 1) + 8;
    end
    return 2 * cycles;
  endfunction

// ====================
// one layer run
// ====================

  task automatic start_layer(input case_t c);
    total_in   = c.total_in;
    total_out  = c.total_out;
    img_size   = c.img_size;
    in_offset  = c.in_offset;
    out_offset = c.out_offset;
    net_offset = c.net_offset;
    req        = 1'b1;
    @(negedge clk);
    req        = 1'b0;
    check_equal("ack low after accepted req", DWIDTH'(ack), '0);
    if (c.stray_req) begin
      repeat (3) @(negedge clk);
      check_equal("ack low before stray req", DWIDTH'(ack), '0);
      // new fields under a req that must be ignored
      total_in   = LWIDTH'(7);
      total_out  = LWIDTH'(6);
      img_size   = LWIDTH'(2);
      in_offset  = '0;
      out_offset = '0;
      net_offset = '0;
      req        = 1'b1;
      @(negedge clk);
      req        = 1'b0;
    end
    while (!ack)
      @(negedge clk);
  endtask

  task automatic run_case(input int idx);
    case_t                    c;
    int                       npix;
    int                       ti;
    int                       groups;
    int                       acc;
    int                       o;
    logic        [DWIDTH-1:0] w;
    logic signed [DWIDTH-1:0] rd;
    c      = CASES[idx];
    npix   = int'(c.img_size) * int'(c.img_size);
    ti     = int'(c.total_in);
    groups = int'(c.total_out) / CORES;
    for (int a = 0; a < IMG_WORDS; a++)
      img_model[a] = background(a, idx);
    for (int ch = 0; ch < ti; ch++)
      for (int p = 0; p < npix; p++) begin
        random_word(c.mask, w);
        img_model[int'(c.in_offset) + ch * npix + p] = w;
      end
    for (int oc = 0; oc < int'(c.total_out); oc++) begin
      for (int ch = 0; ch < ti; ch++) begin
        random_word(c.mask, w);
        weight[oc][ch] = w;
      end
      random_word(c.mask, w);
      bias[oc] = w;
    end
    // bank k holds the weights of all inputs and then the bias per group
    for (int g = 0; g < groups; g++)
      for (int k = 0; k < CORES; k++) begin
        o = g * CORES + k;
        for (int ch = 0; ch < ti; ch++)
          write_net(k, int'(c.net_offset) + g * (ti + 1) + ch, weight[o][ch]);
        write_net(k, int'(c.net_offset) + g * (ti + 1) + ti, bias[o]);
      end
    for (int a = 0; a < IMG_WORDS; a++)
      write_img(a, img_model[a]);
    for (int oc = 0; oc < int'(c.total_out); oc++)
      for (int p = 0; p < npix; p++) begin
        acc = int'(bias[oc]);
        for (int ch = 0; ch < ti; ch++)
          acc = acc + int'(img_model[int'(c.in_offset) + ch * npix + p]) * int'(weight[oc][ch]);
        img_model[int'(c.out_offset) + oc * npix + p] = acc[DWIDTH-1:0];
      end
    start_layer(c);
    for (int a = 0; a < IMG_WORDS; a++) begin
      read_img(a, rd);
      check_equal($sformatf("case %0d image word %0d", idx, a), rd, img_model[a]);
    end
  endtask

// ====================
// main sequence
// ====================

  initial begin
    xrst       = 1'b0;
    req        = 1'b0;
    total_in   = '0;
    total_out  = '0;
    img_size   = '0;
    in_offset  = '0;
    out_offset = '0;
    net_offset = '0;
    net_we     = 1'b0;
    net_sel    = '0;
    net_addr   = '0;
    net_wdata  = '0;
    img_we     = 1'b0;
    img_addr   = '0;
    img_wdata  = '0;
    lfsr_state = 16'd78;
    repeat (16) @(negedge clk);
    check_equal("ack during reset", DWIDTH'(ack), DWIDTH'(1));
    xrst = 1'b1;
    @(negedge clk);
    check_equal("ack after reset", DWIDTH'(ack), DWIDTH'(1));
    for (int i = 0; i < NCASES; i++)
      run_case(i);
    $display("TESTS PASSED");
    $finish;
  end

  initial begin : watchdog
    int limit;
    limit = run_budget();
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d clock cycles", limit);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock
  #( parameter int PERIOD_NS = 100
   )
  ( output logic clk
  );

  // free-running, starts low
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

// ==== hw/conv_unit.sv ====
`timescale 1ns/100ps

module conv_unit
  import conv_pkg::*, ctrl_pkg::*;
  ( input  logic                    clk
  , input  logic                    xrst
  , input  logic                    req
  , output logic                    ack
  , input  logic        [LWIDTH-1:0]  total_in
  , input  logic        [LWIDTH-1:0]  total_out
  , input  logic        [LWIDTH-1:0]  img_size
  , input  logic        [IMGSIZE-1:0] in_offset
  , input  logic        [IMGSIZE-1:0] out_offset
  , input  logic        [NETSIZE-1:0] net_offset
  , input  logic                    net_we
  , input  logic        [CORELOG-1:0] net_sel
  , input  logic        [NETSIZE-1:0] net_addr
  , input  logic signed [DWIDTH-1:0]  net_wdata
  , input  logic                    img_we
  , input  logic        [IMGSIZE-1:0] img_addr
  , input  logic signed [DWIDTH-1:0]  img_wdata
  , output logic signed [DWIDTH-1:0]  img_rdata
  );

  core_ctrl_t               core_ctrl;
  logic        [NETSIZE-1:0] net_raddr;
  logic signed [DWIDTH-1:0]  net_rdata [CORES];
  logic signed [DWIDTH-1:0]  out_data  [CORES];
  logic        [PIXLOG-1:0]  serial_addr;

  img_port_if i_img_port ();

  conv_ctrl i_conv_ctrl
    ( .clk
    , .xrst
    , .req
    , .total_in
    , .total_out
    , .img_size
    , .in_offset
    , .out_offset
    , .net_offset
    , .out_data
    , .ack
    , .core_ctrl
    , .net_raddr
    , .serial_addr
    , .img         (i_img_port.ctrl)
    );

  img_mem i_img_mem
    ( .clk
    , .host_we    (img_we)
    , .host_addr  (img_addr)
    , .host_wdata (img_wdata)
    , .host_rdata (img_rdata)
    , .port       (i_img_port.mem)
    );

  net_mem i_net_mem
    ( .clk
    , .net_we
    , .net_sel
    , .net_addr
    , .net_wdata
    , .raddr     (net_raddr)
    , .rdata     (net_rdata)
    );

  for (genvar k = 0; k < CORES; k++) begin : g_core
    conv_core i_conv_core
      ( .clk
      , .xrst
      , .ctrl        (core_ctrl)
      , .net_rdata   (net_rdata[k])
      , .pix         (i_img_port.reader)
      , .serial_addr
      , .out_data    (out_data[k])
      );
  end

endmodule

// ==== hw/net_mem.sv ====
`timescale 1ns/100ps

module net_mem
  import conv_pkg::*;
  ( input  logic                    clk
  , input  logic                    net_we
  , input  logic        [CORELOG-1:0] net_sel
  , input  logic        [NETSIZE-1:0] net_addr
  , input  logic signed [DWIDTH-1:0]  net_wdata
  , input  logic        [NETSIZE-1:0] raddr
  , output logic signed [DWIDTH-1:0]  rdata [CORES]
  );

  // one bank per core
  logic signed [DWIDTH-1:0] bank [CORES][2**NETSIZE];

  // host writes one bank, controller reads all banks at once
  always_ff @(posedge clk)
    for (int k = 0; k < CORES; k++) begin
      if (net_we && net_sel == CORELOG'(k))
        bank[k][net_addr] <= net_wdata;
      rdata[k] <= bank[k][raddr];
    end

endmodule

// ==== hw/img_mem.sv ====
`timescale 1ns/100ps

module img_mem
  import conv_pkg::*;
  ( input  logic                    clk
  , input  logic                    host_we
  , input  logic        [IMGSIZE-1:0] host_addr
  , input  logic signed [DWIDTH-1:0]  host_wdata
  , output logic signed [DWIDTH-1:0]  host_rdata
  , img_port_if.mem                 port
  );

  logic signed [DWIDTH-1:0] mem [2**IMGSIZE];

  // ====================
  // two ports, registered reads
  // ====================

  // controller write wins on an address clash
  always_ff @(posedge clk) begin
    if (host_we)
      mem[host_addr] <= host_wdata;
    if (port.we)
      mem[port.addr] <= port.wdata;
    host_rdata <= mem[host_addr];
    port.rdata <= mem[port.addr];
  end

endmodule

// ==== hw/conv_core.sv ====
`timescale 1ns/100ps

module conv_core
  import conv_pkg::*, ctrl_pkg::*;
  ( input  logic                    clk
  , input  logic                    xrst
  , input  core_ctrl_t              ctrl
  , input  logic signed [DWIDTH-1:0] net_rdata
  , img_port_if.reader              pix
  , input  logic        [PIXLOG-1:0] serial_addr
  , output logic signed [DWIDTH-1:0] out_data
  );

  logic signed [DWIDTH-1:0] r_weight;
  logic signed [DWIDTH-1:0] r_bias;
  logic signed [DWIDTH-1:0] buffer [MAX_PIX];
  logic        [PIXLOG:0]   r_pix;
  logic        [PIXLOG:0]   pix_idx;
  logic        [PIXLOG-1:0] wr_addr;
  logic signed [DWIDTH-1:0] product;
  logic signed [DWIDTH-1:0] acc_base;
  logic signed [DWIDTH-1:0] bias_term;
  logic signed [DWIDTH-1:0] acc_next;

  always_ff @(posedge clk) begin
    if (ctrl.wreg_we)
      r_weight <= net_rdata;
    if (ctrl.breg_we)
      r_bias <= net_rdata;
  end

  // pixel index restarts on the first word of each phase
  assign pix_idx = ctrl.start ? '0 : r_pix;
  assign wr_addr = pix_idx[PIXLOG-1:0];

  always_ff @(posedge clk)
    if (!xrst)
      r_pix <= '0;
    else if (ctrl.pix_en)
      r_pix <= pix_idx + (PIXLOG+1)'(1);
    else if (ctrl.start)
      r_pix <= '0;

  // all sums wrap at DWIDTH
  assign product   = pix.rdata * r_weight;
  assign acc_base  = ctrl.first_input ? '0 : buffer[wr_addr];
  assign bias_term = ctrl.last_input ? r_bias : '0;
  assign acc_next  = acc_base + product + bias_term;

  always_ff @(posedge clk) begin
    if (ctrl.pix_en)
      buffer[wr_addr] <= acc_next;
    // forward a same-cycle write, seen with 1x1 images
    if (ctrl.pix_en && wr_addr == serial_addr)
      out_data <= acc_next;
    else
      out_data <= buffer[serial_addr];
  end

  a_pix_in_range: assert property (
    @(posedge clk) disable iff (!xrst)
    ctrl.pix_en |-> pix_idx < (PIXLOG+1)'(MAX_PIX));

endmodule

// ==== hw/conv_ctrl.sv ====
`timescale 1ns/100ps

module conv_ctrl
  import conv_pkg::*, ctrl_pkg::*;
  ( input  logic                     clk
  , input  logic                     xrst
  , input  logic                     req
  , input  logic        [LWIDTH-1:0]  total_in
  , input  logic        [LWIDTH-1:0]  total_out
  , input  logic        [LWIDTH-1:0]  img_size
  , input  logic        [IMGSIZE-1:0] in_offset
  , input  logic        [IMGSIZE-1:0] out_offset
  , input  logic        [NETSIZE-1:0] net_offset
  , input  logic signed [DWIDTH-1:0]  out_data [CORES]
  , output logic                     ack
  , output core_ctrl_t               core_ctrl
  , output logic        [NETSIZE-1:0] net_raddr
  , output logic        [PIXLOG-1:0]  serial_addr
  , img_port_if.ctrl                 img
  );

  phase_t                  r_state;
  enum logic {W_WEIGHT, W_BIAS} r_wstate;
  logic [LWIDTH-1:0]       r_total_in;
  logic [LWIDTH-1:0]       r_total_out;
  logic [LWIDTH-1:0]       r_count_in;
  logic [LWIDTH-1:0]       r_count_out;
  logic [IMGSIZE-1:0]      r_npix;
  logic [IMGSIZE-1:0]      r_in_offset;
  logic [IMGSIZE-1:0]      r_out_offset;
  logic [NETSIZE-1:0]      r_net_offset;
  logic [NETSIZE-1:0]      r_net_cnt;
  logic [IMGSIZE-1:0]      r_pix_cnt;
  logic [IMGSIZE-1:0]      r_in_addr;
  logic [IMGSIZE-1:0]      r_out_addr;
  logic [PIXLOG-1:0]       r_rd_pix;
  logic [CORELOG-1:0]      r_rd_core;
  logic                    r_rd_over;
  logic                    go;
  logic                    last_in;
  logic                    last_group;
  logic                    network_end;
  logic                    input_end;
  logic                    output_end;
  logic                    rd_valid;
  logic                    rd_pix_last;
  logic                    rd_last;
  core_ctrl_t              ctrl_d;
  logic [CORELOG:0]        tag_d;
  logic [CORELOG:0]        tag_q;

  assign go          = req && ack;
  assign last_in     = r_count_in == r_total_in - LWIDTH'(1);
  assign last_group  = r_count_out + LWIDTH'(CORES) >= r_total_out;
  assign network_end = r_state == PH_NETWORK && (!last_in || r_wstate == W_BIAS);
  assign input_end   = r_state == PH_INPUT && r_pix_cnt == r_npix - IMGSIZE'(1);

// ====================
// main FSM
// ====================

  always_ff @(posedge clk)
    if (!xrst) begin
      r_state     <= PH_WAIT;
      r_count_in  <= '0;
      r_count_out <= '0;
    end
    else
      case (r_state)
        PH_WAIT:
          if (go)
            r_state <= PH_NETWORK;
        PH_NETWORK:
          if (network_end)
            r_state <= PH_INPUT;
        PH_INPUT:
          if (input_end)
            if (last_in) begin
              r_state    <= PH_OUTPUT;
              r_count_in <= '0;
            end
            else begin
              r_state    <= PH_NETWORK;
              r_count_in <= r_count_in + LWIDTH'(1);
            end
        PH_OUTPUT:
          if (output_end)
            if (last_group) begin
              r_state     <= PH_WAIT;
              r_count_out <= '0;
            end
            else begin
              r_state     <= PH_NETWORK;
              r_count_out <= r_count_out + LWIDTH'(CORES);
            end
        default:
          r_state <= PH_WAIT;
      endcase

  // layer setup, latched on an accepted req
  always_ff @(posedge clk)
    if (!xrst) begin
      r_total_in   <= '0;
      r_total_out  <= '0;
      r_npix       <= '0;
      r_in_offset  <= '0;
      r_out_offset <= '0;
      r_net_offset <= '0;
    end
    else if (go) begin
      r_total_in   <= total_in;
      r_total_out  <= total_out;
      r_npix       <= IMGSIZE'(img_size) * IMGSIZE'(img_size);
      r_in_offset  <= in_offset;
      r_out_offset <= out_offset;
      r_net_offset <= net_offset;
    end

  // WAIT with ack low is the cycle of the last output write
  always_ff @(posedge clk)
    if (!xrst)
      ack <= 1'b1;
    else if (go)
      ack <= 1'b0;
    else if (r_state == PH_WAIT)
      ack <= 1'b1;

// ====================
// network and input
// ====================

  always_ff @(posedge clk)
    if (!xrst)
      r_wstate <= W_WEIGHT;
    else if (r_state == PH_NETWORK)
      r_wstate <= (r_wstate == W_WEIGHT && last_in) ? W_BIAS : W_WEIGHT;

  always_ff @(posedge clk)
    if (!xrst) begin
      r_net_cnt <= '0;
      net_raddr <= '0;
    end
    else if (ack)
      r_net_cnt <= '0;
    else if (r_state == PH_NETWORK) begin
      net_raddr <= r_net_offset + r_net_cnt;
      r_net_cnt <= r_net_cnt + NETSIZE'(1);
    end

  // input address runs over all channels, rewinds per group
  always_ff @(posedge clk)
    if (!xrst) begin
      r_pix_cnt <= '0;
      r_in_addr <= '0;
    end
    else if (r_state == PH_INPUT) begin
      r_pix_cnt <= input_end ? '0 : r_pix_cnt + IMGSIZE'(1);
      r_in_addr <= r_in_addr + IMGSIZE'(1);
    end
    else if (r_state == PH_OUTPUT)
      r_in_addr <= '0;

  assign ctrl_d.start       = (r_state == PH_NETWORK && r_wstate == W_WEIGHT)
                           || (r_state == PH_INPUT && r_pix_cnt == '0);
  assign ctrl_d.pix_en      = r_state == PH_INPUT;
  assign ctrl_d.first_input = r_state == PH_INPUT && r_count_in == '0;
  assign ctrl_d.last_input  = r_state == PH_INPUT && last_in;
  assign ctrl_d.wreg_we     = r_state == PH_NETWORK && r_wstate == W_WEIGHT;
  assign ctrl_d.breg_we     = r_state == PH_NETWORK && r_wstate == W_BIAS;

  delay_line #(.T(core_ctrl_t), .DEPTH(RD_DELAY)) i_ctrl_dly
    ( .clk
    , .xrst
    , .d   (ctrl_d)
    , .q   (core_ctrl)
    );

// ====================
// serial readout
// ====================

  assign rd_valid    = r_state == PH_OUTPUT && !r_rd_over;
  assign rd_pix_last = IMGSIZE'(r_rd_pix) == r_npix - IMGSIZE'(1);
  assign rd_last     = rd_valid && rd_pix_last && r_rd_core == CORELOG'(CORES - 1);
  // pixel counter doubles as drain counter once all reads are out
  assign output_end  = r_rd_over && r_rd_pix == PIXLOG'(RD_DELAY - 1);

  always_ff @(posedge clk)
    if (!xrst) begin
      r_rd_pix    <= '0;
      r_rd_core   <= '0;
      r_rd_over   <= 1'b0;
      serial_addr <= '0;
    end
    else if (rd_valid) begin
      serial_addr <= r_rd_pix;
      if (rd_pix_last) begin
        r_rd_pix  <= '0;
        r_rd_core <= (r_rd_core == CORELOG'(CORES - 1)) ? '0 : r_rd_core + CORELOG'(1);
      end
      else
        r_rd_pix <= r_rd_pix + PIXLOG'(1);
      if (rd_last)
        r_rd_over <= 1'b1;
    end
    else if (r_rd_over)
      if (output_end) begin
        r_rd_over   <= 1'b0;
        r_rd_pix    <= '0;
        serial_addr <= '0;
      end
      else
        r_rd_pix <= r_rd_pix + PIXLOG'(1);

  // write enable and source core, aligned with out_data
  assign tag_d = {rd_valid, r_rd_core};

  delay_line #(.T(logic [CORELOG:0]), .DEPTH(RD_DELAY)) i_tag_dly
    ( .clk
    , .xrst
    , .d   (tag_d)
    , .q   (tag_q)
    );

  always_ff @(posedge clk)
    if (!xrst)
      r_out_addr <= '0;
    else if (ack)
      r_out_addr <= '0;
    else if (tag_q[CORELOG])
      r_out_addr <= r_out_addr + IMGSIZE'(1);

  always_ff @(posedge clk)
    if (!xrst) begin
      img.we   <= 1'b0;
      img.addr <= '0;
    end
    else begin
      img.we   <= tag_q[CORELOG];
      img.addr <= tag_q[CORELOG] ? r_out_offset + r_out_addr
                                 : r_in_offset + r_in_addr;
    end

  always_ff @(posedge clk)
    img.wdata <= out_data[tag_q[CORELOG-1:0]];

  a_no_write_while_idle: assert property (
    @(posedge clk) disable iff (!xrst) !(ack && img.we));

  a_serial_addr_range: assert property (
    @(posedge clk) disable iff (!xrst)
    r_state == PH_OUTPUT |-> IMGSIZE'(serial_addr) < r_npix);

endmodule

// ==== hw/delay_line.sv ====
`timescale 1ns/100ps

module delay_line
  #( parameter type T     = logic
   , parameter int  DEPTH = 2
   )
  ( input  logic clk
  , input  logic xrst
  , input  T     d
  , output T     q
  );

  T r_stage [DEPTH];

  always_ff @(posedge clk)
    if (!xrst) begin
      for (int i = 0; i < DEPTH; i++)
        r_stage[i] <= '0;
    end
    else begin
      r_stage[0] <= d;
      for (int i = 1; i < DEPTH; i++)
        r_stage[i] <= r_stage[i-1];
    end

  assign q = r_stage[DEPTH-1];

endmodule

// ==== hw/img_port_if.sv ====
`timescale 1ns/100ps

interface img_port_if;

  logic                               we;
  logic        [conv_pkg::IMGSIZE-1:0] addr;
  logic signed [conv_pkg::DWIDTH-1:0]  wdata;
  logic signed [conv_pkg::DWIDTH-1:0]  rdata;

  // controller side
  modport ctrl (output we, output addr, output wdata);

  modport mem (input we, input addr, input wdata, output rdata);

  // cores only see the read data
  modport reader (input rdata);

endinterface

// ==== hw/ctrl_pkg.sv ====
package ctrl_pkg;

  // controller phases
  typedef enum logic [1:0] {
    PH_WAIT    = 2'd0,
    PH_NETWORK = 2'd1,
    PH_INPUT   = 2'd2,
    PH_OUTPUT  = 2'd3
  } phase_t;

  // control word that travels alongside each memory read
  typedef struct packed {
    logic start;        // first word of a phase
    logic pix_en;
    logic first_input;
    logic last_input;
    logic wreg_we;
    logic breg_we;
  } core_ctrl_t;

endpackage

// ==== hw/conv_pkg.sv ====
package conv_pkg;

  // ====================
  // data path
  // ====================

  // signed pixels, weights, biases and outputs
  localparam int DWIDTH   = 16;
  // layer size fields
  localparam int LWIDTH   = 8;

  // ====================
  // cores and memories
  // ====================

  localparam int CORES    = 2;
  localparam int CORELOG  = 1;

  // image memory address, 1024 words
  localparam int IMGSIZE  = 10;
  // per-bank network memory address
  localparam int NETSIZE  = 6;

  // accumulator buffer, img_size up to 8
  localparam int MAX_PIX  = 64;
  localparam int PIXLOG   = 6;

  // address register plus memory read register
  localparam int RD_DELAY = 2;

endpackage
